// ==== include/jam_settings.svh ====
`ifndef JAM_SETTINGS_SVH
`define JAM_SETTINGS_SVH

// problem size, workers and jobs alike
`define JAM_N 8

// one matrix entry
`define JAM_COST_W 7

// job index, 0 to 7
`define JAM_JOB_W 3

// sum of eight costs, 1016 at most
`define JAM_TOTAL_W 10

// 1-based job number on the output
`define JAM_OUT_JOB_W 4

// entries in a full cost matrix
`define JAM_LOADS 64

`endif

// ==== hdl/jam_types_pkg.sv ====
`include "jam_settings.svh"

package jam_types_pkg;

	// one cost entry
	typedef logic [`JAM_COST_W-1:0] cost_t;

	// job index, 0-based
	typedef logic [`JAM_JOB_W-1:0] job_t;

	// element w is the job of worker w
	typedef job_t [`JAM_N-1:0] perm_t;

	// total cost of one assignment
	typedef logic [`JAM_TOTAL_W-1:0] total_t;

	// job as presented on the output, 1-based
	typedef logic [`JAM_OUT_JOB_W-1:0] out_job_t;

	// all costs of one worker, element j for job j
	typedef cost_t [`JAM_N-1:0] cost_row_t;

endpackage

// ==== hdl/jam_phase_pkg.sv ====
package jam_phase_pkg;

	// controller phases
	typedef enum logic [1:0] {
		PH_LOAD,
		PH_SEARCH,
		PH_DRAIN,
		PH_OUTPUT
	} phase_t;

endpackage

// ==== hdl/cand_if.sv ====
`timescale 1ns/1ps

// one evaluated permutation per valid cycle, no handshake
interface cand_if;

	logic                  valid;
	jam_types_pkg::perm_t  perm;
	jam_types_pkg::total_t total;
	// final permutation of the walk
	logic                  last;

	modport src (
		output valid,
		output perm,
		output total,
		output last
	);

	modport dst (
		input valid,
		input perm,
		input total,
		input last
	);

endinterface

// ==== hdl/cost_matrix.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module cost_matrix (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      load_en,
	input  jam_types_pkg::cost_t      cost_in,
	output jam_types_pkg::cost_row_t  rows [`JAM_N]
);

	jam_types_pkg::cost_t store [`JAM_LOADS];

	// ----------------------------------------
	// shift-in storage
	// ----------------------------------------
	// new cost enters at the top, so the first of 64 ends at entry 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `JAM_LOADS; k++) begin
				store[k] <= '0;
			end
		end else if (load_en) begin
			for (int k = 0; k < `JAM_LOADS - 1; k++) begin
				store[k] <= store[k+1];
			end
			store[`JAM_LOADS-1] <= cost_in;
		end
	end

	// ----------------------------------------
	// row view
	// ----------------------------------------
	// entry (w, j) sits at 8w+j
	always_comb begin
		for (int w = 0; w < `JAM_N; w++) begin
			for (int j = 0; j < `JAM_N; j++) begin
				rows[w][j] = store[w*`JAM_N + j];
			end
		end
	end

endmodule

// ==== hdl/perm_walker.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module perm_walker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	output jam_types_pkg::perm_t perm,
	output logic                 perm_valid,
	output logic                 perm_last
);

	jam_types_pkg::perm_t perm_q;
	jam_types_pkg::perm_t perm_nxt;
	logic                 active;
	logic                 has_ascent;

	// ----------------------------------------
	// next permutation, lexicographic
	// ----------------------------------------
	always_comb begin
		int                   piv;
		int                   pv;
		int                   sw;
		jam_types_pkg::perm_t swp;

		// rightmost ascent
		piv = -1;
		for (int i = 0; i < `JAM_N - 1; i++) begin
			if (perm_q[i] < perm_q[i+1]) begin
				piv = i;
			end
		end
		has_ascent = (piv >= 0);
		pv = has_ascent ? piv : 0;

		// suffix is descending, so the rightmost larger one is the smallest larger
		sw = `JAM_N - 1;
		for (int j = 0; j < `JAM_N; j++) begin
			if (j > pv && perm_q[j] > perm_q[pv]) begin
				sw = j;
			end
		end

		swp = perm_q;
		swp[pv] = perm_q[sw];
		swp[sw] = perm_q[pv];

		// reverse the suffix after the pivot
		perm_nxt = swp;
		for (int k = 0; k < `JAM_N; k++) begin
			if (k > pv) begin
				perm_nxt[k] = swp[`JAM_N + pv - k];
			end
		end
	end

	// ----------------------------------------
	// walk state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			for (int w = 0; w < `JAM_N; w++) begin
				perm_q[w] <= jam_types_pkg::job_t'(w);
			end
		end else if (start) begin
			// restart from the identity
			active <= 1'b1;
			for (int w = 0; w < `JAM_N; w++) begin
				perm_q[w] <= jam_types_pkg::job_t'(w);
			end
		end else if (active) begin
			if (!has_ascent) begin
				active <= 1'b0;
			end else begin
				perm_q <= perm_nxt;
			end
		end
	end

	assign perm       = perm_q;
	assign perm_valid = active;
	// descending order has no ascent left
	assign perm_last  = active && !has_ascent;

endmodule

// ==== hdl/assign_cost_eval.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module assign_cost_eval (
	input  logic                     clk,
	input  logic                     rst_n,
	input  jam_types_pkg::cost_row_t rows [`JAM_N],
	input  jam_types_pkg::perm_t     perm,
	input  logic                     perm_valid,
	input  logic                     perm_last,
	cand_if.src                      cand
);

	jam_types_pkg::total_t sum;

	// ----------------------------------------
	// cost of the current permutation
	// ----------------------------------------
	always_comb begin
		sum = '0;
		for (int w = 0; w < `JAM_N; w++) begin
			// worker w takes job perm[w]
			sum = sum + jam_types_pkg::total_t'(rows[w][perm[w]]);
		end
	end

	// ----------------------------------------
	// candidate register, one cycle latency
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cand.valid <= 1'b0;
			cand.last  <= 1'b0;
		end else begin
			cand.valid <= perm_valid;
			cand.last  <= perm_valid && perm_last;
		end
	end

	// payload follows the flags
	always_ff @(posedge clk) begin
		cand.perm  <= perm;
		cand.total <= sum;
	end

endmodule

// ==== hdl/best_tracker.sv ====
`timescale 1ns/1ps

module best_tracker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clear,
	cand_if.dst                   cand,
	output jam_types_pkg::perm_t  best_perm,
	output jam_types_pkg::total_t best_total
);

	// high from clear until the last candidate is taken
	logic busy;
	logic take;

	// strictly smaller only, so the earliest minimum stays
	assign take = busy && cand.valid && (cand.total < best_total);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			best_total <= '1;
		end else if (clear) begin
			busy       <= 1'b1;
			best_total <= '1;
		end else begin
			if (take) begin
				best_total <= cand.total;
			end
			if (cand.valid && cand.last) begin
				busy <= 1'b0;
			end
		end
	end

	// winning permutation
	always_ff @(posedge clk) begin
		if (take) begin
			best_perm <= cand.perm;
		end
	end

endmodule

// ==== hdl/jam_ctrl.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module jam_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    load_en,
	output logic                    start,
	output logic                    clear,
	input  logic                    perm_last,
	input  jam_types_pkg::perm_t    best_perm,
	input  jam_types_pkg::total_t   best_total,
	output logic                    out_valid,
	output jam_types_pkg::out_job_t out_job,
	output jam_types_pkg::total_t   out_cost
);

	localparam int CNT_W = $clog2(`JAM_LOADS);

	jam_phase_pkg::phase_t phase;
	// load count, drain count and output index share this
	logic [CNT_W-1:0]      cnt;
	logic                  load_done;
	jam_types_pkg::job_t   idx;

	assign load_en   = (phase == jam_phase_pkg::PH_LOAD) && in_valid;
	assign load_done = load_en && (cnt == CNT_W'(`JAM_LOADS - 1));
	assign idx       = cnt[`JAM_JOB_W-1:0];

	// ----------------------------------------
	// phase FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= jam_phase_pkg::PH_LOAD;
			cnt   <= '0;
			start <= 1'b0;
			clear <= 1'b0;
		end else begin
			// start and clear pulse the cycle after the last cost
			start <= load_done;
			clear <= load_done;
			case (phase)
				jam_phase_pkg::PH_LOAD: begin
					if (load_done) begin
						phase <= jam_phase_pkg::PH_SEARCH;
						cnt   <= '0;
					end else if (load_en) begin
						cnt <= cnt + 1'b1;
					end
				end
				jam_phase_pkg::PH_SEARCH: begin
					if (perm_last) begin
						phase <= jam_phase_pkg::PH_DRAIN;
					end
				end
				jam_phase_pkg::PH_DRAIN: begin
					// evaluator and tracker settle in two cycles
					if (cnt == CNT_W'(1)) begin
						phase <= jam_phase_pkg::PH_OUTPUT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (cnt == CNT_W'(`JAM_N - 1)) begin
						phase <= jam_phase_pkg::PH_LOAD;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// ----------------------------------------
	// output registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_job   <= '0;
			out_cost  <= '0;
		end else if (phase == jam_phase_pkg::PH_OUTPUT) begin
			out_valid <= 1'b1;
			out_job   <= jam_types_pkg::out_job_t'(best_perm[idx]) +
				jam_types_pkg::out_job_t'(1);
			out_cost  <= best_total;
		end else begin
			out_valid <= 1'b0;
			out_job   <= '0;
			out_cost  <= '0;
		end
	end

endmodule

// ==== hdl/jam.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module jam (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  jam_types_pkg::cost_t    in_cost,
	output logic                    out_valid,
	output jam_types_pkg::out_job_t out_job,
	output jam_types_pkg::total_t   out_cost
);

	logic                     load_en;
	logic                     start;
	logic                     clear;
	jam_types_pkg::cost_row_t rows [`JAM_N];
	jam_types_pkg::perm_t     perm;
	logic                     perm_valid;
	logic                     perm_last;
	jam_types_pkg::perm_t     best_perm;
	jam_types_pkg::total_t    best_total;

	// evaluator to tracker
	cand_if cand ();

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	cost_matrix cost_matrix_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.load_en (load_en),
		.cost_in (in_cost),
		.rows    (rows)
	);

	perm_walker perm_walker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.perm       (perm),
		.perm_valid (perm_valid),
		.perm_last  (perm_last)
	);

	assign_cost_eval assign_cost_eval_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.rows       (rows),
		.perm       (perm),
		.perm_valid (perm_valid),
		.perm_last  (perm_last),
		.cand       (cand.src)
	);

	best_tracker best_tracker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (clear),
		.cand       (cand.dst),
		.best_perm  (best_perm),
		.best_total (best_total)
	);

	// ----------------------------------------
	// control and output
	// ----------------------------------------
	jam_ctrl jam_ctrl_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.load_en    (load_en),
		.start      (start),
		.clear      (clear),
		.perm_last  (perm_last),
		.best_perm  (best_perm),
		.best_total (best_total),
		.out_valid  (out_valid),
		.out_job    (out_job),
		.out_cost   (out_cost)
	);

endmodule

// ==== tests/jam_checker.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module jam_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    out_valid,
	input jam_types_pkg::out_job_t out_job,
	input jam_types_pkg::total_t   out_cost
);

	// consecutive out_valid cycles seen before this one
	logic [3:0] run_len;

	// assertion failures so far
	int assert_fails = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_len <= '0;
		end else if (!out_valid) begin
			run_len <= '0;
		end else if (run_len != '1) begin
			run_len <= run_len + 1'b1;
		end
	end

	// ----------------------------------------
	// output properties
	// ----------------------------------------
	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("out_valid high while rst_n is low");
			assert_fails++;
		end

	a_job_range: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_job >= jam_types_pkg::out_job_t'(1) &&
			out_job <= jam_types_pkg::out_job_t'(`JAM_N)))
		else begin
			$error("out_job %0d outside 1 to 8", out_job);
			assert_fails++;
		end

	a_cost_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |-> $stable(out_cost))
		else begin
			$error("out_cost changed inside an output burst");
			assert_fails++;
		end

	// one result is eight cycles long
	a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> run_len < 4'(`JAM_N))
		else begin
			$error("out_valid burst longer than 8 cycles");
			assert_fails++;
		end

endmodule

// ==== tests/jam_tb.sv ====
`timescale 1ns/1ps
`include "jam_settings.svh"

module jam_tb;

	localparam int NUM_TESTS       = 6;
	localparam int NUM_PERMS       = 40320;
	// load, search, drain and output take about 40,420 cycles
	localparam int CYCLES_PER_TEST = 50000;
	localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;

	localparam int MODE_ZERO = 0;
	localparam int MODE_ANTI = 1;
	localparam int MODE_MAX  = 2;
	localparam int MODE_RAND = 3;
	localparam int MODE_LOW  = 4;

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	jam_types_pkg::cost_t    in_cost;
	logic                    out_valid;
	jam_types_pkg::out_job_t out_job;
	jam_types_pkg::total_t   out_cost;

	// a cost of -1 leaves the answer to the reference model
	// jobs hold worker 0 in the top nibble
	string       test_name [NUM_TESTS];
	int          test_mode [NUM_TESTS];
	int          test_cost [NUM_TESTS];
	logic [31:0] test_jobs [NUM_TESTS];

	int          mat [`JAM_LOADS];
	int          seed;
	int          cycle_count;
	int          test_errs;
	int          reset_errs;
	int          pass_count;
	int          fail_count;
	int          fails_before;
	int          exp_cost;
	logic [31:0] exp_jobs;

	jam jam_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_cost   (in_cost),
		.out_valid (out_valid),
		.out_job   (out_job),
		.out_cost  (out_cost)
	);

	bind jam jam_checker jam_checker_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_valid (out_valid),
		.out_job   (out_job),
		.out_cost  (out_cost)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("result never arrived within %0d cycles", CYCLE_LIMIT);
		$display("tests failed");
		$finish;
	end

	// ----------------------------------------
	// table and matrices
	// ----------------------------------------
	task automatic add_test(input int idx, input string name, input int mode,
		input int cost, input logic [31:0] jobs);
		test_name[idx] = name;
		test_mode[idx] = mode;
		test_cost[idx] = cost;
		test_jobs[idx] = jobs;
	endtask

	task automatic build_matrix(input int mode);
		int w;
		int j;
		for (int k = 0; k < `JAM_LOADS; k++) begin
			w = k / `JAM_N;
			j = k % `JAM_N;
			case (mode)
				MODE_ZERO: mat[k] = 0;
				MODE_ANTI: mat[k] = (j == `JAM_N - 1 - w) ? 1 : 100;
				MODE_MAX:  mat[k] = 127;
				MODE_RAND: mat[k] = $random(seed) & 127;
				// small costs give lots of ties
				default:   mat[k] = $random(seed) & 3;
			endcase
		end
	endtask

	// walks every permutation in lexicographic order and keeps the first minimum
	task automatic find_cheapest(output int best, output logic [31:0] jobs);
		int p [`JAM_N];
		int total;
		int i;
		int j;
		int t;
		bit more;
		for (int w = 0; w < `JAM_N; w++) begin
			p[w] = w;
		end
		best = 1 << 30;
		jobs = '0;
		more = 1'b1;
		while (more) begin
			total = 0;
			for (int w = 0; w < `JAM_N; w++) begin
				total += mat[w * `JAM_N + p[w]];
			end
			if (total < best) begin
				best = total;
				for (int w = 0; w < `JAM_N; w++) begin
					jobs[31 - 4 * w -: 4] = 4'(p[w] + 1);
				end
			end
			i = `JAM_N - 2;
			while (i >= 0 && p[i] > p[i + 1]) begin
				i--;
			end
			if (i < 0) begin
				more = 1'b0;
			end else begin
				j = `JAM_N - 1;
				while (p[j] < p[i]) begin
					j--;
				end
				t = p[i];
				p[i] = p[j];
				p[j] = t;
				// tail back to ascending
				i = i + 1;
				j = `JAM_N - 1;
				while (i < j) begin
					t = p[i];
					p[i] = p[j];
					p[j] = t;
					i++;
					j--;
				end
			end
		end
	endtask

	// ----------------------------------------
	// drive and check
	// ----------------------------------------
	task automatic load_matrix(input string name);
		for (int k = 0; k < `JAM_LOADS; k++) begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			in_cost  = jam_types_pkg::cost_t'(mat[k]);
			@(negedge clk);
			if (out_valid) begin
				$display("%s: out_valid rose during loading", name);
				test_errs++;
			end
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_cost  = '0;
	endtask

	task automatic check_result(input string name);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!out_valid) begin
			@(negedge clk);
			waited++;
		end
		if (waited < NUM_PERMS) begin
			$display("%s: result came after %0d cycles, too early for a full search",
				name, waited);
			test_errs++;
		end
		for (int w = 0; w < `JAM_N; w++) begin
			if (!out_valid) begin
				$display("%s: out_valid dropped after %0d cycles", name, w);
				test_errs++;
			end
			if (int'(out_cost) != exp_cost) begin
				$display("ERR %s cost on cycle %0d expected %0d actual %0d",
					name, w, exp_cost, out_cost);
				test_errs++;
			end
			if (out_job != exp_jobs[31 - 4 * w -: 4]) begin
				$display("ERR %s job of worker %0d expected %0d actual %0d",
					name, w, exp_jobs[31 - 4 * w -: 4], out_job);
				test_errs++;
			end
			@(negedge clk);
		end
		if (out_valid) begin
			$display("%s: out_valid lasted longer than 8 cycles", name);
			test_errs++;
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_cost    = '0;
		seed       = 12985;
		test_errs  = 0;
		reset_errs = 0;
		pass_count = 0;
		fail_count = 0;
		add_test(0, "zero_matrix", MODE_ZERO, 0, 32'h12345678);
		add_test(1, "anti_diagonal", MODE_ANTI, 8, 32'h87654321);
		add_test(2, "all_max", MODE_MAX, 1016, 32'h12345678);
		add_test(3, "random_a", MODE_RAND, -1, '0);
		add_test(4, "random_b", MODE_RAND, -1, '0);
		add_test(5, "random_ties", MODE_LOW, -1, '0);

		repeat (10) begin
			@(posedge clk);
			#1;
			if (out_valid) begin
				$display("out_valid high during reset");
				reset_errs++;
			end
		end
		rst_n = 1'b1;

		// no reset between entries
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_errs = 0;
			fails_before = jam_inst.jam_checker_inst.assert_fails;
			build_matrix(test_mode[t]);
			if (test_cost[t] < 0) begin
				find_cheapest(exp_cost, exp_jobs);
			end else begin
				exp_cost = test_cost[t];
				exp_jobs = test_jobs[t];
			end
			load_matrix(test_name[t]);
			check_result(test_name[t]);
			if (jam_inst.jam_checker_inst.assert_fails != fails_before) begin
				$display("%s: an output assertion failed", test_name[t]);
				test_errs++;
			end
			if (test_errs == 0) begin
				pass_count++;
				$display("PASS %s cost %0d", test_name[t], exp_cost);
			end else begin
				fail_count++;
				$display("FAIL %s with %0d errors", test_name[t], test_errs);
			end
		end

		$display("run %0d, passed %0d, failed %0d, reset errors %0d, assertion failures %0d",
			NUM_TESTS, pass_count, fail_count, reset_errs,
			jam_inst.jam_checker_inst.assert_fails);
		if (fail_count == 0 && reset_errs == 0 &&
			jam_inst.jam_checker_inst.assert_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hdl/jam_types_pkg.sv
hdl/jam_phase_pkg.sv
hdl/cand_if.sv
hdl/cost_matrix.sv
hdl/perm_walker.sv
hdl/assign_cost_eval.sv
hdl/best_tracker.sv
hdl/jam_ctrl.sv
hdl/jam.sv
tests/jam_checker.sv
tests/jam_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +incdir+%,$(shell cat flist.f)) include/jam_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vjam_tb: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module jam_tb \
		--Mdir obj_dir -o Vjam_tb -f flist.f

run: obj_dir/Vjam_tb
	-obj_dir/Vjam_tb +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
